/* bench/issueCases.txt */
# columns: test fetchInst(hex) expPcHold expIssueInst(hex) expHalted
# one line per clock, a held instruction repeats on the next line
1 C105 0 C105 0
1 C20A 0 C20A 0
1 0800 0 0800 0
1 1000 0 1000 0
1 44A3 0 44A3 0
2 D98C 0 D98C 0
2 DB18 1 0800 0
2 DB18 1 0800 0
2 DB18 1 0800 0
2 DB18 1 0800 0
2 DB18 0 DB18 0
2 D284 0 D284 0
3 C520 0 C520 0
3 82A0 1 0800 0
3 82A0 1 0800 0
3 82A0 1 0800 0
3 82A0 1 0800 0
3 82A0 0 82A0 0
3 8A80 0 8A80 0
3 4201 0 4201 0
3 4421 1 0800 0
3 4421 1 0800 0
3 4421 1 0800 0
3 4421 0 4421 0
3 9EE0 0 9EE0 0
3 8E40 1 0800 0
3 8E40 1 0800 0
3 8E40 1 0800 0
3 8E40 1 0800 0
3 8E40 0 8E40 0
4 6304 0 6304 0
4 C411 1 0800 0
4 C411 1 0800 0
4 C411 0 C411 0
5 0000 1 0000 0
5 0000 1 0800 0
5 0000 1 0800 0
5 0000 1 0800 0
5 0000 1 0800 0
5 0000 1 0800 1
5 0000 1 0800 1
5 0000 1 0800 1

/* bench/issueFrontTb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the issue stage top level.
// Replays the case file one line per clock. It drives the fetched
// instruction on the falling edge and checks pcHold, issueInst
// and halted just before the next rising edge.
// Run from the project root so the case file path resolves.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module issueFrontTb;

    import isaPkg::*;

    localparam int halfPeriod   = 4;
    // 1 ns ahead of the rising edge
    localparam int sampleDelay  = 3;
    localparam int resetCycles  = 8;
    localparam int readyTimeout = 16;
    localparam int maxLines     = 500;

    logic                 clk;
    logic                 rstN;
    logic [instWidth-1:0] fetchInst;
    logic [instWidth-1:0] issueInst;
    logic                 pcHold;
    logic                 halted;

    int errorCount;
    int checkCount;
    int testsRun;
    int testsFailed;
    int curTest;
    int curErrors;
    bit aborted;

    issueFront dut (
        .clk       (clk),
        .rstN      (rstN),
        .fetchInst (fetchInst),
        .issueInst (issueInst),
        .pcHold    (pcHold),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // quiet stage, bubble out and nothing held
    function automatic bit dutIdle();
        return (issueInst == nopInst) && !pcHold && !halted;
    endfunction

    task automatic checkOutputs(input logic expHold, input logic [instWidth-1:0] expInst,
                                input logic expHalted);
        checkCount += 3;
        if (pcHold !== expHold) begin
            $display("Fail at %0t: pcHold expected %0b got %0b", $time, expHold, pcHold);
            curErrors++;
        end
        if (issueInst !== expInst) begin
            $display("Fail at %0t: issueInst expected %h got %h", $time, expInst, issueInst);
            curErrors++;
        end
        if (halted !== expHalted) begin
            $display("Fail at %0t: halted expected %0b got %0b", $time, expHalted, halted);
            curErrors++;
        end
    endtask

    // one result line per test number
    task automatic closeTest();
        testsRun++;
        errorCount += curErrors;
        if (curErrors == 0) begin
            $display("test %0d ok", curTest);
        end else begin
            testsFailed++;
            $display("test %0d failed with %0d errors", curTest, curErrors);
        end
        curErrors = 0;
    endtask

    task automatic replayCases();
        int                   fd;
        int                   lineNo;
        int                   fields;
        int                   readLen;
        int                   fileTest;
        int                   fileHold;
        int                   fileHalted;
        bit                   isComment;
        logic [instWidth-1:0] fileInst;
        logic [instWidth-1:0] fileExp;
        string                line;
        fd = $fopen("bench/issueCases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file bench/issueCases.txt");
            aborted = 1'b1;
        end else begin
            lineNo  = 0;
            curTest = -1;
            // bounded read until end of file
            while (!$feof(fd) && lineNo < maxLines) begin
                lineNo++;
                line      = "";
                readLen   = $fgets(line, fd);
                isComment = (readLen == 0) || (line.len() == 0) || (line.getc(0) == "#");
                fields    = $sscanf(line, "%d %h %d %h %d", fileTest, fileInst, fileHold,
                                    fileExp, fileHalted);
                if (!isComment && fields == 5) begin
                    if (fileTest != curTest) begin
                        if (curTest >= 0) begin
                            closeTest();
                        end
                        curTest = fileTest;
                    end
                    @(negedge clk);
                    fetchInst = fileInst;
                    #sampleDelay;
                    checkOutputs(fileHold[0], fileExp, fileHalted[0]);
                end else if (!isComment && fields > 0) begin
                    $display("case file line %0d has %0d fields, expected 5", lineNo, fields);
                    errorCount++;
                end
            end
            if (curTest >= 0) begin
                closeTest();
            end
            if (!$feof(fd)) begin
                $display("case file not at its end after %0d lines, read stopped", maxLines);
                aborted = 1'b1;
            end
            if (testsRun == 0) begin
                $display("case file held no test lines");
                aborted = 1'b1;
            end
            $fclose(fd);
        end
    endtask

    initial begin : mainFlow
        int waitCnt;
        errorCount  = 0;
        checkCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        curTest     = -1;
        curErrors   = 0;
        aborted     = 1'b0;
        rstN        = 1'b0;
        fetchInst   = nopInst;
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rstN = 1'b1;
        // stage must come out of reset quiet
        waitCnt = 0;
        #sampleDelay;
        while (!dutIdle() && waitCnt < readyTimeout) begin
            @(negedge clk);
            #sampleDelay;
            waitCnt++;
        end
        if (!dutIdle()) begin
            $display("DUT outputs not idle %0d cycles after reset release", readyTimeout);
            aborted = 1'b1;
        end else begin
            replayCases();
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0 && !aborted) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/drainCounter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Drain timer for halt.
// Loads the drain length when halt issues and pulses done for
// one cycle on the last drain cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module drainCounter (
    input  logic clk,
    input  logic rstN,
    input  logic drainStart,
    output logic drainDone
);

    import pipePkg::*;

    logic [drainCntWidth-1:0] count;

    // zero means idle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (drainStart) begin
            count <= drainCntWidth'(drainCycles);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last bubble cycle
    assign drainDone = count == drainCntWidth'(1);

    // only one halt can be draining
    assert property (@(posedge clk) disable iff (!rstN)
        drainStart |-> (count == '0))
        else $error("drainCounter: drainStart while draining");

endmodule

`default_nettype wire

/* design/hazardDetect.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard check for the fetched instruction.
// Compares its source registers against the writer records of
// D, X, M and W and adds the branch shadow. Passes the fetched
// instruction on, or a NOP bubble when it must wait.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module hazardDetect (
    input  logic [isaPkg::instWidth-1:0]                            fetchInst,
    input  logic [pipePkg::trackDepth-1:0]                          regWrt,
    input  logic [pipePkg::trackDepth-1:0][isaPkg::regAddrWidth-1:0] wrtReg,
    input  logic [pipePkg::trackDepth-1:0]                          branchIn,
    output logic                                                    stall,
    output logic [isaPkg::instWidth-1:0]                            candInst,
    output logic                                                    isBranch
);

    import isaPkg::*;
    import pipePkg::*;

    logic [opWidth-1:0]      opcode;
    logic [regAddrWidth-1:0] srcS;
    logic [regAddrWidth-1:0] srcT;
    logic                    rsHit;
    logic                    rtHit;
    logic                    regStall;
    logic                    shadow;

    // field pick
    assign opcode = fetchInst[opMsb:opLsb];
    assign srcS   = fetchInst[rsMsb:rsLsb];
    // store data reg sits in this field too
    assign srcT   = fetchInst[rtMsb:rtLsb];

    // match each source against every in-flight writer
    always_comb begin
        rsHit = 1'b0;
        rtHit = 1'b0;
        for (int i = 0; i < trackDepth; i++) begin
            if (regWrt[i] && (wrtReg[i] == srcS)) begin
                rsHit = 1'b1;
            end
            if (regWrt[i] && (wrtReg[i] == srcT)) begin
                rtHit = 1'b1;
            end
        end
    end

    // which sources count depends on the opcode class
    always_comb begin
        regStall = 1'b0;
        if (isSysOp(opcode)) begin
            // halt, nop, siic, rti read nothing
            regStall = 1'b0;
        end else if ((opcode == opSt) || (opcode == opStu)) begin
            // address base plus data reg
            regStall = rsHit || rtHit;
        end else if ((opcode == opArith) || (opcode == opBitOp) || isSetOp(opcode)) begin
            regStall = rsHit || rtHit;
        end else begin
            // immediates, loads, branches
            regStall = rsHit;
        end
    end

    assign isBranch = isBranchOp(opcode);

    // nothing issues under a branch still in D or X
    assign shadow = branchIn[stageD] || branchIn[stageX];

    always_comb begin
        stall    = regStall || shadow;
        candInst = stall ? nopInst : fetchInst;
    end

endmodule

`default_nettype wire

/* design/isaPkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set definitions for the 16-bit teaching core.
// Holds the opcode values, field positions and the bubble
// encoding. Issue logic imports it for decode.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package isaPkg;

    localparam int instWidth    = 16;
    localparam int regAddrWidth = 3;
    localparam int opWidth      = 5;

    // field positions
    localparam int opMsb = 15;
    localparam int opLsb = 11;
    localparam int rsMsb = 10;
    localparam int rsLsb = 8;
    localparam int rtMsb = 7;
    localparam int rtLsb = 5;
    // R-format destination
    localparam int rdMsb = 4;
    localparam int rdLsb = 2;

    localparam logic [opWidth-1:0] opHalt  = 5'b00000;
    localparam logic [opWidth-1:0] opNop   = 5'b00001;
    localparam logic [opWidth-1:0] opSt    = 5'b10000;
    localparam logic [opWidth-1:0] opLd    = 5'b10001;
    localparam logic [opWidth-1:0] opSlbi  = 5'b10010;
    localparam logic [opWidth-1:0] opStu   = 5'b10011;
    localparam logic [opWidth-1:0] opLbi   = 5'b11000;
    localparam logic [opWidth-1:0] opBitOp = 5'b11010;
    localparam logic [opWidth-1:0] opArith = 5'b11011;

    // group prefixes, upper opcode bits
    localparam logic [2:0] opSysPfx    = 3'b000;
    localparam logic [2:0] opSetPfx    = 3'b111;
    localparam logic [1:0] opImmPfx    = 2'b01;
    localparam logic [2:0] opBranchPfx = 3'b011;

    localparam logic [instWidth-1:0] nopInst = {opNop, 11'b0};
    localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

    // halt, nop, siic, rti
    function automatic logic isSysOp(input logic [opWidth-1:0] op);
        return op[4:2] == opSysPfx;
    endfunction

    function automatic logic isSetOp(input logic [opWidth-1:0] op);
        return op[4:2] == opSetPfx;
    endfunction

    function automatic logic isBranchOp(input logic [opWidth-1:0] op);
        return op[4:2] == opBranchPfx;
    endfunction

    // I-format 1 is 01xxx minus the branches
    function automatic logic isImm1Op(input logic [opWidth-1:0] op);
        return (op[4:3] == opImmPfx) && !isBranchOp(op);
    endfunction

endpackage

`default_nettype wire

/* design/issueControl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue FSM with run, drain and halted states.
// Steers the issued instruction and the PC hold, and starts the
// drain timer when a halt leaves the stage.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module issueControl (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [isaPkg::instWidth-1:0] fetchInst,
    input  logic [isaPkg::instWidth-1:0] candInst,
    input  logic                         stall,
    input  logic                         drainDone,
    output logic [isaPkg::instWidth-1:0] issueInst,
    output logic                         pcHold,
    output logic                         issueValid,
    output logic                         drainStart,
    output logic                         halted
);

    import isaPkg::*;
    import pipePkg::*;

    issueState state;
    issueState nextState;
    logic      fetchHalt;

    assign fetchHalt = fetchInst[opMsb:opLsb] == opHalt;

    always_comb begin
        nextState  = state;
        issueInst  = nopInst;
        pcHold     = 1'b1;
        issueValid = 1'b0;
        drainStart = 1'b0;
        case (state)
            issueRun: begin
                issueInst  = candInst;
                issueValid = !stall;
                // halt holds the PC in the cycle it issues
                pcHold     = stall || fetchHalt;
                if (fetchHalt && !stall) begin
                    drainStart = 1'b1;
                    nextState  = issueDrain;
                end
            end
            issueDrain: begin
                if (drainDone) begin
                    nextState = issueHalted;
                end
            end
            default: begin
                // halted, wait for reset
                nextState = issueHalted;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= issueRun;
        end else begin
            state <= nextState;
        end
    end

    assign halted = state == issueHalted;

    // halted is entered only at the end of a drain
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(halted) |-> $past(drainDone))
        else $error("issueControl: halted without a finished drain");

endmodule

`default_nettype wire

/* design/issueFront.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue stage top level.
// Fetch drives fetchInst each cycle; decode latches issueInst at
// the rising edge. pcHold tells fetch to present the same
// instruction again.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module issueFront (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [isaPkg::instWidth-1:0] fetchInst,
    output logic [isaPkg::instWidth-1:0] issueInst,
    output logic                         pcHold,
    output logic                         halted
);

    import isaPkg::*;
    import pipePkg::*;

    logic                                   stall;
    logic [instWidth-1:0]                   candInst;
    logic                                   issueValid;
    logic                                   drainStart;
    logic                                   drainDone;
    logic [trackDepth-1:0]                  regWrt;
    logic [trackDepth-1:0][regAddrWidth-1:0] wrtReg;
    logic [trackDepth-1:0]                  branchIn;

    // tracker decodes branches from issueInst itself
    hazardDetect uHazard (
        .fetchInst (fetchInst),
        .regWrt    (regWrt),
        .wrtReg    (wrtReg),
        .branchIn  (branchIn),
        .stall     (stall),
        .candInst  (candInst),
        .isBranch  ()
    );

    writeTracker uTracker (
        .clk        (clk),
        .rstN       (rstN),
        .issueInst  (issueInst),
        .issueValid (issueValid),
        .regWrt     (regWrt),
        .wrtReg     (wrtReg),
        .branchIn   (branchIn)
    );

    issueControl uControl (
        .clk        (clk),
        .rstN       (rstN),
        .fetchInst  (fetchInst),
        .candInst   (candInst),
        .stall      (stall),
        .drainDone  (drainDone),
        .issueInst  (issueInst),
        .pcHold     (pcHold),
        .issueValid (issueValid),
        .drainStart (drainStart),
        .halted     (halted)
    );

    drainCounter uDrain (
        .clk        (clk),
        .rstN       (rstN),
        .drainStart (drainStart),
        .drainDone  (drainDone)
    );

endmodule

`default_nettype wire

/* design/pipePkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline shape seen from the issue stage.
// Tracked stage count and slot indices, the halt drain length
// and the issue FSM state encoding.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pipePkg;

    // D, X, M, W behind issue
    localparam int trackDepth = 4;

    // slot index in the tracker, youngest first
    localparam int stageD = 0;
    localparam int stageX = 1;

    // cycles of bubbles after halt issues
    localparam int drainCycles   = 4;
    localparam int drainCntWidth = $clog2(drainCycles + 1);

    typedef enum logic [1:0] {
        issueRun,
        issueDrain,
        issueHalted
    } issueState;

endpackage

`default_nettype wire

/* design/writeTracker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writer and branch records for the stages behind issue.
// Decodes the destination of each issued instruction, enters it
// at D and shifts it one stage per clock toward W.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module writeTracker (
    input  logic                                                    clk,
    input  logic                                                    rstN,
    input  logic [isaPkg::instWidth-1:0]                            issueInst,
    input  logic                                                    issueValid,
    output logic [pipePkg::trackDepth-1:0]                          regWrt,
    output logic [pipePkg::trackDepth-1:0][isaPkg::regAddrWidth-1:0] wrtReg,
    output logic [pipePkg::trackDepth-1:0]                          branchIn
);

    import isaPkg::*;
    import pipePkg::*;

    logic [opWidth-1:0]      opcode;
    logic [regAddrWidth-1:0] newDest;
    logic                    newWrt;
    logic                    newBranch;

    assign opcode = issueInst[opMsb:opLsb];

    // destination field per opcode
    always_comb begin
        newWrt    = 1'b0;
        newBranch = 1'b0;
        // non-writers park on r7, regWrt masks it
        newDest   = linkReg;
        if ((opcode == opArith) || (opcode == opBitOp) || isSetOp(opcode)) begin
            newWrt  = 1'b1;
            newDest = issueInst[rdMsb:rdLsb];
        end else if (isImm1Op(opcode) || (opcode == opLd)) begin
            newWrt  = 1'b1;
            newDest = issueInst[rtMsb:rtLsb];
        end else if ((opcode == opLbi) || (opcode == opSlbi) || (opcode == opStu)) begin
            // stu writes back the updated base
            newWrt  = 1'b1;
            newDest = issueInst[rsMsb:rsLsb];
        end else if (isBranchOp(opcode)) begin
            newBranch = 1'b1;
        end
    end

    // valid bits, bubbles enter empty
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWrt   <= '0;
            branchIn <= '0;
        end else begin
            regWrt   <= {regWrt[trackDepth-2:0], newWrt && issueValid};
            branchIn <= {branchIn[trackDepth-2:0], newBranch && issueValid};
        end
    end

    // register numbers ride along with their valid bit
    always_ff @(posedge clk) begin
        wrtReg <= {wrtReg[trackDepth-2:0], newDest};
    end

    // branches write nothing, in any stage
    assert property (@(posedge clk) disable iff (!rstN) (branchIn & regWrt) == '0)
        else $error("writeTracker: branch record with regWrt set");

endmodule

`default_nettype wire

/* filelist.f */
design/isaPkg.sv
design/pipePkg.sv
design/hazardDetect.sv
design/writeTracker.sv
design/issueControl.sv
design/drainCounter.sv
design/issueFront.sv
bench/issueFrontTb.sv

/* run.sh */
#!/bin/sh
# Build and run the issue stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

verilator --binary --timing --assert -f filelist.f --top-module issueFrontTb -o issueFrontSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/issueFrontSim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
